// File: src/sched_pkg.sv
`default_nettype none

package sched_pkg;

  // ==============================
  // register file sizes
  // ==============================
  localparam int ARCH_REG_NUM = 32;
  localparam int PHY_REG_NUM  = 48;
  localparam int AREG_W       = 5;
  localparam int PREG_W       = 6;

  // physical registers beyond the arch set start out free
  localparam int FREE_NUM = PHY_REG_NUM - ARCH_REG_NUM;
  localparam int FL_PTR_W = $clog2(FREE_NUM);
  localparam int FL_CNT_W = $clog2(FREE_NUM + 1);

  // ==============================
  // queue sizes
  // ==============================
  localparam int RS_SIZE  = 4;
  localparam int RS_IDX_W = $clog2(RS_SIZE);
  localparam int MQ_SIZE  = 4;
  localparam int MQ_IDX_W = $clog2(MQ_SIZE);
  localparam int MQ_CNT_W = $clog2(MQ_SIZE + 1);

  // unit class codes
  localparam logic FU_ALU = 1'b0;
  localparam logic FU_MEM = 1'b1;

  // one op word, read per unit class
  typedef union packed {
    logic [3:0] alu_op;
    struct packed {
      logic       is_store;
      logic [1:0] size;
      logic       sign_ext;
    } mem;
  } op_word_u;

endpackage

`default_nettype wire

// File: src/rs_wr_if.sv
`default_nettype none

interface rs_wr_if;
  import sched_pkg::*;

  logic              valid;
  logic              ready;
  logic [PREG_W-1:0] psrc0;
  logic [PREG_W-1:0] psrc1;
  logic              src0_rdy;
  logic              src1_rdy;
  logic [PREG_W-1:0] pdest;
  op_word_u          op;

  // rename side
  modport stage_mp (
    output valid, psrc0, psrc1, src0_rdy, src1_rdy, pdest, op,
    input  ready
  );

  // queue side, ready means a free entry
  modport queue_mp (
    input  valid, psrc0, psrc1, src0_rdy, src1_rdy, pdest, op,
    output ready
  );

endinterface

`default_nettype wire

// File: src/free_list.sv
`default_nettype none

module free_list (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         alloc_i,
  output logic                         empty_o,
  output logic [sched_pkg::PREG_W-1:0] alloc_preg_o,
  input  logic                         free_valid_i,
  input  logic [sched_pkg::PREG_W-1:0] free_preg_i
);
  import sched_pkg::*;

  logic [PREG_W-1:0]   fifo_q [FREE_NUM];
  logic [FL_PTR_W-1:0] head_q;
  logic [FL_PTR_W-1:0] tail_q;
  logic [FL_CNT_W-1:0] count_q;
  logic                pop;

  // head is always visible, pop only when something is there
  assign empty_o      = (count_q == '0);
  assign alloc_preg_o = fifo_q[head_q];
  assign pop          = alloc_i & ~empty_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // full at reset, holding 32..47 in order
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= FL_CNT_W'(FREE_NUM);
      for (int i = 0; i < FREE_NUM; i++) begin
        fifo_q[i] <= PREG_W'(ARCH_REG_NUM + i);
      end
    end else begin
      if (pop) begin
        head_q <= head_q + 1'b1;
      end
      if (free_valid_i) begin
        fifo_q[tail_q] <= free_preg_i;
        tail_q         <= tail_q + 1'b1;
      end
      // pop and push may land in the same cycle
      count_q <= count_q + FL_CNT_W'(free_valid_i) - FL_CNT_W'(pop);
    end
  end

endmodule

`default_nettype wire

// File: src/rename_table.sv
`default_nettype none

module rename_table (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [sched_pkg::AREG_W-1:0] src0_i,
  input  logic [sched_pkg::AREG_W-1:0] src1_i,
  input  logic [sched_pkg::AREG_W-1:0] dest_i,
  input  logic                         rename_i,
  input  logic [sched_pkg::PREG_W-1:0] new_preg_i,
  output logic [sched_pkg::PREG_W-1:0] psrc0_o,
  output logic [sched_pkg::PREG_W-1:0] psrc1_o,
  output logic                         src0_rdy_o,
  output logic                         src1_rdy_o,
  input  logic                         wb_valid_i,
  input  logic [sched_pkg::PREG_W-1:0] wb_pdest_i
);
  import sched_pkg::*;

  logic [PREG_W-1:0]      map_q [ARCH_REG_NUM];
  logic [PHY_REG_NUM-1:0] ready_q;

  // ==============================
  // lookup
  // ==============================
  // r0 is hardwired to p0 and always ready
  assign psrc0_o = (src0_i == '0) ? '0 : map_q[src0_i];
  assign psrc1_o = (src1_i == '0) ? '0 : map_q[src1_i];

  // same-cycle writeback bypass
  assign src0_rdy_o = (src0_i == '0) | ready_q[psrc0_o] |
                      (wb_valid_i & (wb_pdest_i == psrc0_o));
  assign src1_rdy_o = (src1_i == '0) | ready_q[psrc1_o] |
                      (wb_valid_i & (wb_pdest_i == psrc1_o));

  // ==============================
  // update
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < ARCH_REG_NUM; i++) begin
        map_q[i] <= PREG_W'(i);
      end
      ready_q <= '1;
    end else begin
      if (wb_valid_i) begin
        ready_q[wb_pdest_i] <= 1'b1;
      end
      // new producer, value not yet written
      if (rename_i) begin
        map_q[dest_i]       <= new_preg_i;
        ready_q[new_preg_i] <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/rename_stage.sv
`default_nettype none

module rename_stage (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  input  logic                         in_fu_i,
  input  sched_pkg::op_word_u          in_op_i,
  input  logic [sched_pkg::AREG_W-1:0] in_arch_dest_i,
  input  logic [sched_pkg::AREG_W-1:0] in_arch_src0_i,
  input  logic [sched_pkg::AREG_W-1:0] in_arch_src1_i,
  input  logic                         wb_valid_i,
  input  logic [sched_pkg::PREG_W-1:0] wb_pdest_i,
  input  logic                         free_valid_i,
  input  logic [sched_pkg::PREG_W-1:0] free_preg_i,
  rs_wr_if.stage_mp                    alu_wr,
  rs_wr_if.stage_mp                    mem_wr
);
  import sched_pkg::*;

  logic              ready_en_q;
  logic              fl_empty;
  logic [PREG_W-1:0] fl_preg;
  logic              dest_nz;
  logic              accept;
  logic              alloc;
  logic              wr_fire;
  logic [PREG_W-1:0] rt_psrc0;
  logic [PREG_W-1:0] rt_psrc1;
  logic              rt_rdy0;
  logic              rt_rdy1;

  // stage register
  logic              s_valid_q;
  logic              s_fu_q;
  op_word_u          s_op_q;
  logic [PREG_W-1:0] s_psrc0_q;
  logic [PREG_W-1:0] s_psrc1_q;
  logic [PREG_W-1:0] s_pdest_q;
  logic              s_rdy0_q;
  logic              s_rdy1_q;
  logic              rdy0_now;
  logic              rdy1_now;

  // ==============================
  // acceptance
  // ==============================
  assign dest_nz = (in_arch_dest_i != '0);
  assign wr_fire = s_valid_q & ((s_fu_q == FU_ALU) ? alu_wr.ready : mem_wr.ready);

  // no allocation needed for r0
  assign in_ready_o = ready_en_q & (~s_valid_q | wr_fire) & (~dest_nz | ~fl_empty);
  assign accept     = in_valid_i & in_ready_o;
  assign alloc      = accept & dest_nz;

  free_list u_free_list (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_i      (alloc),
    .empty_o      (fl_empty),
    .alloc_preg_o (fl_preg),
    .free_valid_i (free_valid_i),
    .free_preg_i  (free_preg_i)
  );

  rename_table u_rename_table (
    .clk        (clk),
    .rst_n      (rst_n),
    .src0_i     (in_arch_src0_i),
    .src1_i     (in_arch_src1_i),
    .dest_i     (in_arch_dest_i),
    .rename_i   (alloc),
    .new_preg_i (fl_preg),
    .psrc0_o    (rt_psrc0),
    .psrc1_o    (rt_psrc1),
    .src0_rdy_o (rt_rdy0),
    .src1_rdy_o (rt_rdy1),
    .wb_valid_i (wb_valid_i),
    .wb_pdest_i (wb_pdest_i)
  );

  // ==============================
  // stage register
  // ==============================
  // wakeup while waiting, also seen by the queue in the write cycle
  assign rdy0_now = s_rdy0_q | (wb_valid_i & (wb_pdest_i == s_psrc0_q));
  assign rdy1_now = s_rdy1_q | (wb_valid_i & (wb_pdest_i == s_psrc1_q));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_en_q <= 1'b0;
      s_valid_q  <= 1'b0;
    end else begin
      ready_en_q <= 1'b1;
      if (accept) begin
        s_valid_q <= 1'b1;
      end else if (wr_fire) begin
        s_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      s_fu_q    <= in_fu_i;
      s_op_q    <= in_op_i;
      s_psrc0_q <= rt_psrc0;
      s_psrc1_q <= rt_psrc1;
      s_pdest_q <= dest_nz ? fl_preg : '0;
      s_rdy0_q  <= rt_rdy0;
      s_rdy1_q  <= rt_rdy1;
    end else begin
      s_rdy0_q <= rdy0_now;
      s_rdy1_q <= rdy1_now;
    end
  end

  // ==============================
  // steering
  // ==============================
  assign alu_wr.valid    = s_valid_q & (s_fu_q == FU_ALU);
  assign alu_wr.psrc0    = s_psrc0_q;
  assign alu_wr.psrc1    = s_psrc1_q;
  assign alu_wr.src0_rdy = rdy0_now;
  assign alu_wr.src1_rdy = rdy1_now;
  assign alu_wr.pdest    = s_pdest_q;
  assign alu_wr.op       = s_op_q;

  assign mem_wr.valid    = s_valid_q & (s_fu_q == FU_MEM);
  assign mem_wr.psrc0    = s_psrc0_q;
  assign mem_wr.psrc1    = s_psrc1_q;
  assign mem_wr.src0_rdy = rdy0_now;
  assign mem_wr.src1_rdy = rdy1_now;
  assign mem_wr.pdest    = s_pdest_q;
  assign mem_wr.op       = s_op_q;

endmodule

`default_nettype wire

// File: src/reservation_station.sv
`default_nettype none

module reservation_station (
  input  logic                         clk,
  input  logic                         rst_n,
  rs_wr_if.queue_mp                    wr,
  input  logic                         wb_valid_i,
  input  logic [sched_pkg::PREG_W-1:0] wb_pdest_i,
  input  logic                         issue_ready_i,
  output logic                         issue_valid_o,
  output logic [sched_pkg::PREG_W-1:0] issue_psrc0_o,
  output logic [sched_pkg::PREG_W-1:0] issue_psrc1_o,
  output logic [sched_pkg::PREG_W-1:0] issue_pdest_o,
  output sched_pkg::op_word_u          issue_op_o
);
  import sched_pkg::*;

  logic [RS_SIZE-1:0] ent_valid_q;
  logic [RS_SIZE-1:0] ent_rdy0_q;
  logic [RS_SIZE-1:0] ent_rdy1_q;
  logic [PREG_W-1:0]  ent_psrc0_q [RS_SIZE];
  logic [PREG_W-1:0]  ent_psrc1_q [RS_SIZE];
  logic [PREG_W-1:0]  ent_pdest_q [RS_SIZE];
  op_word_u           ent_op_q    [RS_SIZE];

  logic [RS_IDX_W-1:0] free_idx;
  logic [RS_IDX_W-1:0] sel_idx;
  logic                sel_found;
  logic                do_write;
  logic                do_issue;

  assign wr.ready = ~&ent_valid_q;
  assign do_write = wr.valid & wr.ready;
  assign do_issue = issue_ready_i & sel_found;

  // lowest free slot and lowest ready entry
  always_comb begin
    free_idx  = '0;
    sel_idx   = '0;
    sel_found = 1'b0;
    for (int i = RS_SIZE - 1; i >= 0; i--) begin
      if (!ent_valid_q[i]) begin
        free_idx = RS_IDX_W'(i);
      end
      if (ent_valid_q[i] && ent_rdy0_q[i] && ent_rdy1_q[i]) begin
        sel_idx   = RS_IDX_W'(i);
        sel_found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ent_valid_q   <= '0;
      issue_valid_o <= 1'b0;
    end else begin
      // output holds under back-pressure
      if (issue_ready_i) begin
        issue_valid_o <= sel_found;
      end
      if (do_issue) begin
        ent_valid_q[sel_idx] <= 1'b0;
      end
      if (do_write) begin
        ent_valid_q[free_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    // wakeup
    for (int i = 0; i < RS_SIZE; i++) begin
      if (wb_valid_i && ent_psrc0_q[i] == wb_pdest_i) begin
        ent_rdy0_q[i] <= 1'b1;
      end
      if (wb_valid_i && ent_psrc1_q[i] == wb_pdest_i) begin
        ent_rdy1_q[i] <= 1'b1;
      end
    end
    if (do_write) begin
      ent_psrc0_q[free_idx] <= wr.psrc0;
      ent_psrc1_q[free_idx] <= wr.psrc1;
      ent_rdy0_q[free_idx]  <= wr.src0_rdy;
      ent_rdy1_q[free_idx]  <= wr.src1_rdy;
      ent_pdest_q[free_idx] <= wr.pdest;
      ent_op_q[free_idx]    <= wr.op;
    end
    if (do_issue) begin
      issue_psrc0_o <= ent_psrc0_q[sel_idx];
      issue_psrc1_o <= ent_psrc1_q[sel_idx];
      issue_pdest_o <= ent_pdest_q[sel_idx];
      issue_op_o    <= ent_op_q[sel_idx];
    end
  end

endmodule

`default_nettype wire

// File: src/order_queue.sv
`default_nettype none

module order_queue (
  input  logic                         clk,
  input  logic                         rst_n,
  rs_wr_if.queue_mp                    wr,
  input  logic                         wb_valid_i,
  input  logic [sched_pkg::PREG_W-1:0] wb_pdest_i,
  input  logic                         issue_ready_i,
  output logic                         issue_valid_o,
  output logic [sched_pkg::PREG_W-1:0] issue_psrc0_o,
  output logic [sched_pkg::PREG_W-1:0] issue_psrc1_o,
  output logic [sched_pkg::PREG_W-1:0] issue_pdest_o,
  output sched_pkg::op_word_u          issue_op_o
);
  import sched_pkg::*;

  logic [MQ_SIZE-1:0]  q_rdy0_q;
  logic [MQ_SIZE-1:0]  q_rdy1_q;
  logic [PREG_W-1:0]   q_psrc0_q [MQ_SIZE];
  logic [PREG_W-1:0]   q_psrc1_q [MQ_SIZE];
  logic [PREG_W-1:0]   q_pdest_q [MQ_SIZE];
  op_word_u            q_op_q    [MQ_SIZE];
  logic [MQ_IDX_W-1:0] head_q;
  logic [MQ_IDX_W-1:0] tail_q;
  logic [MQ_CNT_W-1:0] count_q;

  logic head_ok;
  logic do_write;
  logic do_issue;

  // only the head may leave, keeping program order
  assign head_ok  = (count_q != '0) & q_rdy0_q[head_q] & q_rdy1_q[head_q];
  assign wr.ready = (count_q != MQ_CNT_W'(MQ_SIZE));
  assign do_write = wr.valid & wr.ready;
  assign do_issue = issue_ready_i & head_ok;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q        <= '0;
      tail_q        <= '0;
      count_q       <= '0;
      issue_valid_o <= 1'b0;
    end else begin
      if (issue_ready_i) begin
        issue_valid_o <= head_ok;
      end
      if (do_issue) begin
        head_q <= head_q + 1'b1;
      end
      if (do_write) begin
        tail_q <= tail_q + 1'b1;
      end
      count_q <= count_q + MQ_CNT_W'(do_write) - MQ_CNT_W'(do_issue);
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < MQ_SIZE; i++) begin
      if (wb_valid_i && q_psrc0_q[i] == wb_pdest_i) begin
        q_rdy0_q[i] <= 1'b1;
      end
      if (wb_valid_i && q_psrc1_q[i] == wb_pdest_i) begin
        q_rdy1_q[i] <= 1'b1;
      end
    end
    if (do_write) begin
      q_psrc0_q[tail_q] <= wr.psrc0;
      q_psrc1_q[tail_q] <= wr.psrc1;
      q_rdy0_q[tail_q]  <= wr.src0_rdy;
      q_rdy1_q[tail_q]  <= wr.src1_rdy;
      q_pdest_q[tail_q] <= wr.pdest;
      q_op_q[tail_q]    <= wr.op;
    end
    if (do_issue) begin
      issue_psrc0_o <= q_psrc0_q[head_q];
      issue_psrc1_o <= q_psrc1_q[head_q];
      issue_pdest_o <= q_pdest_q[head_q];
      issue_op_o    <= q_op_q[head_q];
    end
  end

endmodule

`default_nettype wire

// File: src/scheduler.sv
`default_nettype none

module scheduler (
  input  logic                         clk,
  input  logic                         rst_n,
  // instruction in
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  input  logic                         in_fu_i,
  input  sched_pkg::op_word_u          in_op_i,
  input  logic [sched_pkg::AREG_W-1:0] in_arch_dest_i,
  input  logic [sched_pkg::AREG_W-1:0] in_arch_src0_i,
  input  logic [sched_pkg::AREG_W-1:0] in_arch_src1_i,
  // writeback and commit free
  input  logic                         wb_valid_i,
  input  logic [sched_pkg::PREG_W-1:0] wb_pdest_i,
  input  logic                         free_valid_i,
  input  logic [sched_pkg::PREG_W-1:0] free_preg_i,
  // ALU issue
  output logic                         alu_valid_o,
  input  logic                         alu_ready_i,
  output logic [sched_pkg::PREG_W-1:0] alu_psrc0_o,
  output logic [sched_pkg::PREG_W-1:0] alu_psrc1_o,
  output logic [sched_pkg::PREG_W-1:0] alu_pdest_o,
  output sched_pkg::op_word_u          alu_op_o,
  // memory issue
  output logic                         mem_valid_o,
  input  logic                         mem_ready_i,
  output logic [sched_pkg::PREG_W-1:0] mem_psrc0_o,
  output logic [sched_pkg::PREG_W-1:0] mem_psrc1_o,
  output logic [sched_pkg::PREG_W-1:0] mem_pdest_o,
  output sched_pkg::op_word_u          mem_op_o
);

  rs_wr_if alu_wr_if ();
  rs_wr_if mem_wr_if ();

  rename_stage u_rename_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .in_fu_i        (in_fu_i),
    .in_op_i        (in_op_i),
    .in_arch_dest_i (in_arch_dest_i),
    .in_arch_src0_i (in_arch_src0_i),
    .in_arch_src1_i (in_arch_src1_i),
    .wb_valid_i     (wb_valid_i),
    .wb_pdest_i     (wb_pdest_i),
    .free_valid_i   (free_valid_i),
    .free_preg_i    (free_preg_i),
    .alu_wr         (alu_wr_if.stage_mp),
    .mem_wr         (mem_wr_if.stage_mp)
  );

  // out-of-order ALU side
  reservation_station u_alu_rs (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr            (alu_wr_if.queue_mp),
    .wb_valid_i    (wb_valid_i),
    .wb_pdest_i    (wb_pdest_i),
    .issue_ready_i (alu_ready_i),
    .issue_valid_o (alu_valid_o),
    .issue_psrc0_o (alu_psrc0_o),
    .issue_psrc1_o (alu_psrc1_o),
    .issue_pdest_o (alu_pdest_o),
    .issue_op_o    (alu_op_o)
  );

  // in-order memory side
  order_queue u_mem_q (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr            (mem_wr_if.queue_mp),
    .wb_valid_i    (wb_valid_i),
    .wb_pdest_i    (wb_pdest_i),
    .issue_ready_i (mem_ready_i),
    .issue_valid_o (mem_valid_o),
    .issue_psrc0_o (mem_psrc0_o),
    .issue_psrc1_o (mem_psrc1_o),
    .issue_pdest_o (mem_pdest_o),
    .issue_op_o    (mem_op_o)
  );

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`default_nettype none

module tb_clock #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // release away from the rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: bench/tb_scheduler.sv
`default_nettype none

module tb_scheduler;
  import sched_pkg::*;

  localparam int REC_WORDS    = 9;
  localparam int MAX_REC      = 64;
  localparam int CYC_PER_REC  = 60;
  localparam int DRAIN_CYCLES = 200;

  // record kinds in the trace
  localparam logic [7:0] K_INSTR = 8'h00;
  localparam logic [7:0] K_WB    = 8'h01;
  localparam logic [7:0] K_FREE  = 8'h02;
  localparam logic [7:0] K_IDLE  = 8'h03;
  localparam logic [7:0] K_HOLD  = 8'h04;
  localparam logic [7:0] K_END   = 8'h0f;

  logic              clk;
  logic              rst_n;
  logic              in_valid;
  logic              in_ready;
  logic              in_fu;
  op_word_u          in_op;
  logic [AREG_W-1:0] in_dest;
  logic [AREG_W-1:0] in_src0;
  logic [AREG_W-1:0] in_src1;
  logic              wb_valid;
  logic [PREG_W-1:0] wb_pdest;
  logic              free_valid;
  logic [PREG_W-1:0] free_preg;
  logic              alu_valid;
  logic              alu_ready;
  logic [PREG_W-1:0] alu_psrc0;
  logic [PREG_W-1:0] alu_psrc1;
  logic [PREG_W-1:0] alu_pdest;
  op_word_u          alu_op;
  logic              mem_valid;
  logic              mem_ready;
  logic [PREG_W-1:0] mem_psrc0;
  logic [PREG_W-1:0] mem_psrc1;
  logic [PREG_W-1:0] mem_pdest;
  op_word_u          mem_op;

  logic [7:0]  trace_mem [MAX_REC * REC_WORDS];
  // expected issue word is {op, psrc0, psrc1, pdest}
  logic [21:0] alu_exp [$];
  logic [21:0] mem_exp [$];
  logic [63:0] busy;
  logic [31:0] lfsr;
  logic        alu_held;
  logic        mem_held;
  logic [21:0] alu_held_word;
  logic [21:0] mem_held_word;
  logic [21:0] alu_word;
  logic [21:0] mem_word;

  assign alu_word = {alu_op, alu_psrc0, alu_psrc1, alu_pdest};
  assign mem_word = {mem_op, mem_psrc0, mem_psrc1, mem_pdest};

  tb_clock #(.PERIOD(8), .RESET_CYCLES(16)) u_tb_clock (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  scheduler u_scheduler (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid_i     (in_valid),
    .in_ready_o     (in_ready),
    .in_fu_i        (in_fu),
    .in_op_i        (in_op),
    .in_arch_dest_i (in_dest),
    .in_arch_src0_i (in_src0),
    .in_arch_src1_i (in_src1),
    .wb_valid_i     (wb_valid),
    .wb_pdest_i     (wb_pdest),
    .free_valid_i   (free_valid),
    .free_preg_i    (free_preg),
    .alu_valid_o    (alu_valid),
    .alu_ready_i    (alu_ready),
    .alu_psrc0_o    (alu_psrc0),
    .alu_psrc1_o    (alu_psrc1),
    .alu_pdest_o    (alu_pdest),
    .alu_op_o       (alu_op),
    .mem_valid_o    (mem_valid),
    .mem_ready_i    (mem_ready),
    .mem_psrc0_o    (mem_psrc0),
    .mem_psrc1_o    (mem_psrc1),
    .mem_pdest_o    (mem_pdest),
    .mem_op_o       (mem_op)
  );

  // ==============================
  // checks
  // ==============================
  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_preg(string name, logic [sched_pkg::PREG_W-1:0] exp_val,
                            logic [sched_pkg::PREG_W-1:0] act_val);
    if (act_val !== exp_val) begin
      $display("FAIL %s expected 0x%h actual 0x%h", name, exp_val, act_val);
      abort_run();
    end
  endtask

  // mem_view compares only the memory fields
  task automatic check_op(string name, sched_pkg::op_word_u exp_val,
                          sched_pkg::op_word_u act_val, logic mem_view);
    logic bad;
    if (mem_view) begin
      bad = (act_val.mem !== exp_val.mem);
    end else begin
      bad = (act_val.alu_op !== exp_val.alu_op);
    end
    if (bad) begin
      $display("FAIL %s expected 0x%h actual 0x%h", name, exp_val, act_val);
      abort_run();
    end
  endtask

  task automatic check_woken(string unit, logic [PREG_W-1:0] preg);
    if (busy[preg]) begin
      $display("ERROR: %s issued with source 0x%h before its writeback", unit, preg);
      abort_run();
    end
  endtask

  // handshake outputs stay idle through reset
  task automatic check_reset_state();
    if (in_ready !== 1'b0 || alu_valid !== 1'b0 || mem_valid !== 1'b0) begin
      $display("ERROR: in_ready_o or an issue valid is not low at reset release");
      abort_run();
    end
  endtask

  task automatic check_still_held(string unit, logic [21:0] held, logic valid_now,
                                  logic [21:0] now);
    if (!valid_now) begin
      $display("ERROR: %s_valid_o dropped while %s_ready_i was low", unit, unit);
      abort_run();
    end
    check_preg({unit, "_psrc0_o"}, held[17:12], now[17:12]);
    check_preg({unit, "_psrc1_o"}, held[11:6], now[11:6]);
    check_preg({unit, "_pdest_o"}, held[5:0], now[5:0]);
    check_op({unit, "_op_o"}, held[21:18], now[21:18], 1'b0);
  endtask

  // out-of-order side matched by pdest
  task automatic take_alu_issue();
    int          idx;
    logic [21:0] e;
    idx = -1;
    for (int i = 0; i < alu_exp.size(); i++) begin
      if (idx < 0 && alu_exp[i][5:0] == alu_pdest) begin
        idx = i;
      end
    end
    if (idx < 0) begin
      $display("ERROR: ALU issued pdest 0x%h that no pending instruction expects",
               alu_pdest);
      abort_run();
    end else begin
      e = alu_exp[idx];
      check_preg("alu_psrc0_o", e[17:12], alu_psrc0);
      check_preg("alu_psrc1_o", e[11:6], alu_psrc1);
      check_op("alu_op_o", e[21:18], alu_op, 1'b0);
      check_woken("ALU", alu_psrc0);
      check_woken("ALU", alu_psrc1);
      alu_exp.delete(idx);
    end
  endtask

  // in-order side in strict FIFO order
  task automatic take_mem_issue();
    logic [21:0] e;
    if (mem_exp.size() == 0) begin
      $display("ERROR: memory issue of pdest 0x%h with nothing pending", mem_pdest);
      abort_run();
    end else begin
      e = mem_exp.pop_front();
      check_preg("mem_pdest_o", e[5:0], mem_pdest);
      check_preg("mem_psrc0_o", e[17:12], mem_psrc0);
      check_preg("mem_psrc1_o", e[11:6], mem_psrc1);
      check_op("mem_op_o", e[21:18], mem_op, 1'b1);
      check_woken("memory", mem_psrc0);
      check_woken("memory", mem_psrc1);
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      if (alu_held) begin
        check_still_held("alu", alu_held_word, alu_valid, alu_word);
      end
      if (mem_held) begin
        check_still_held("mem", mem_held_word, mem_valid, mem_word);
      end
      if (alu_valid && alu_ready) begin
        take_alu_issue();
      end
      if (mem_valid && mem_ready) begin
        take_mem_issue();
      end
      alu_held      = alu_valid & ~alu_ready;
      alu_held_word = alu_word;
      mem_held      = mem_valid & ~mem_ready;
      mem_held_word = mem_word;
    end
  end

  // ==============================
  // random back-pressure
  // ==============================
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  initial begin
    lfsr      = 32'h5b4e_56af;
    alu_ready = 1'b0;
    mem_ready = 1'b0;
    forever begin
      @(negedge clk);
      lfsr      = lfsr_next(lfsr);
      alu_ready = lfsr[0];
      lfsr      = lfsr_next(lfsr);
      mem_ready = lfsr[0];
    end
  end

  // ==============================
  // trace drivers
  // ==============================
  task automatic drive_instr(int base);
    logic              accepted;
    logic              fu;
    logic [3:0]        op;
    logic [PREG_W-1:0] e0;
    logic [PREG_W-1:0] e1;
    logic [PREG_W-1:0] ed;
    fu       = trace_mem[base + 1][0];
    op       = trace_mem[base + 2][3:0];
    e0       = trace_mem[base + 6][PREG_W-1:0];
    e1       = trace_mem[base + 7][PREG_W-1:0];
    ed       = trace_mem[base + 8][PREG_W-1:0];
    in_valid = 1'b1;
    in_fu    = fu;
    in_op    = op;
    in_dest  = trace_mem[base + 3][AREG_W-1:0];
    in_src0  = trace_mem[base + 4][AREG_W-1:0];
    in_src1  = trace_mem[base + 5][AREG_W-1:0];
    accepted = 1'b0;
    while (!accepted) begin
      @(posedge clk);
      accepted = in_ready;
      @(negedge clk);
    end
    in_valid = 1'b0;
    // new producer stays busy until its writeback
    if (ed != '0) begin
      busy[ed] = 1'b1;
    end
    if (fu == FU_MEM) begin
      mem_exp.push_back({op, e0, e1, ed});
    end else begin
      alu_exp.push_back({op, e0, e1, ed});
    end
  endtask

  task automatic drive_wb(logic [PREG_W-1:0] preg);
    wb_valid   = 1'b1;
    wb_pdest   = preg;
    busy[preg] = 1'b0;
    @(negedge clk);
    wb_valid = 1'b0;
  endtask

  task automatic drive_free(logic [PREG_W-1:0] preg);
    free_valid = 1'b1;
    free_preg  = preg;
    @(negedge clk);
    free_valid = 1'b0;
  endtask

  // offer a renaming instruction while no register is free
  task automatic check_stalled(int cycles);
    in_valid = 1'b1;
    in_fu    = FU_ALU;
    in_op    = '0;
    in_dest  = AREG_W'(1);
    in_src0  = '0;
    in_src1  = '0;
    repeat (cycles) begin
      @(posedge clk);
      if (in_ready) begin
        $display("ERROR: in_ready_o high while the free list should be empty");
        abort_run();
      end
      @(negedge clk);
    end
    in_valid = 1'b0;
  endtask

  function automatic int count_records();
    int n;
    n = 0;
    while (n < MAX_REC && trace_mem[n * REC_WORDS] !== K_END) begin
      n++;
    end
    return n;
  endfunction

  task automatic run_watchdog(int cycles);
    repeat (cycles) @(posedge clk);
    $display("ERROR: timeout, run not finished after %0d cycles", cycles);
    abort_run();
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    int         n_rec;
    int         timeout_cycles;
    int         base;
    int         drain;
    logic [7:0] kind;
    logic [7:0] arg;
    in_valid   = 1'b0;
    in_fu      = 1'b0;
    in_op      = '0;
    in_dest    = '0;
    in_src0    = '0;
    in_src1    = '0;
    wb_valid   = 1'b0;
    wb_pdest   = '0;
    free_valid = 1'b0;
    free_preg  = '0;
    busy       = '0;
    alu_held   = 1'b0;
    mem_held   = 1'b0;
    $readmemh("bench/sched_trace.txt", trace_mem);
    n_rec          = count_records();
    timeout_cycles = n_rec * CYC_PER_REC;
    fork
      run_watchdog(timeout_cycles);
    join_none
    wait (rst_n === 1'b1);
    check_reset_state();
    @(negedge clk);
    for (int r = 0; r < n_rec; r++) begin
      base = r * REC_WORDS;
      kind = trace_mem[base];
      arg  = trace_mem[base + 1];
      case (kind)
        K_INSTR: drive_instr(base);
        K_WB:    drive_wb(arg[PREG_W-1:0]);
        K_FREE:  drive_free(arg[PREG_W-1:0]);
        K_IDLE:  repeat (int'(arg)) @(negedge clk);
        K_HOLD:  check_stalled(int'(arg));
        default: begin
          $display("ERROR: trace record %0d has unknown kind 0x%h", r, kind);
          abort_run();
        end
      endcase
    end
    drain = 0;
    while ((alu_exp.size() != 0 || mem_exp.size() != 0) && drain < DRAIN_CYCLES) begin
      @(negedge clk);
      drain++;
    end
    // a few more cycles to catch any duplicate issue
    repeat (10) @(negedge clk);
    if (alu_exp.size() == 0 && mem_exp.size() == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("ERROR: %0d ALU and %0d memory instructions never issued",
               alu_exp.size(), mem_exp.size());
      abort_run();
    end
  end

endmodule

`default_nettype wire

// File: bench/sched_trace.txt
// kind cls op dest src0 src1 exp_psrc0 exp_psrc1 exp_pdest, hex, nine words per record
// kind 0 instr, 1 wb, 2 free, 3 idle, 4 stall check, f end; non-instr arg in cls column
0 0 3 01 02 03 02 03 20
0 0 5 04 01 05 20 05 21
0 0 7 06 02 02 02 02 22
0 1 c 00 04 06 21 22 00
0 1 5 07 01 00 20 00 23
0 1 3 08 09 00 09 00 24
0 0 a 09 0a 0b 0a 0b 25
3 08 0 00 00 00 00 00 00
1 20 0 00 00 00 00 00 00
3 04 0 00 00 00 00 00 00
1 22 0 00 00 00 00 00 00
1 21 0 00 00 00 00 00 00
1 23 0 00 00 00 00 00 00
1 24 0 00 00 00 00 00 00
1 25 0 00 00 00 00 00 00
3 0a 0 00 00 00 00 00 00
// dependency chain
0 0 1 01 01 07 20 23 26
0 0 2 0a 01 04 26 21 27
0 1 8 00 0a 01 27 26 00
1 26 0 00 00 00 00 00 00
1 27 0 00 00 00 00 00 00
3 08 0 00 00 00 00 00 00
// use up the rest of the free list
0 0 4 0b 03 00 03 00 28
0 0 4 0c 0b 00 28 00 29
0 0 4 0d 02 00 02 00 2a
0 0 4 0e 02 00 02 00 2b
1 28 0 00 00 00 00 00 00
0 0 4 0f 0c 00 29 00 2c
0 0 4 10 03 00 03 00 2d
0 1 1 11 05 00 05 00 2e
0 0 4 12 11 00 2e 00 2f
1 29 0 00 00 00 00 00 00
1 2e 0 00 00 00 00 00 00
4 06 0 00 00 00 00 00 00
3 0a 0 00 00 00 00 00 00
// refill and reuse in free order
2 20 0 00 00 00 00 00 00
2 01 0 00 00 00 00 00 00
0 0 6 13 01 0a 26 27 20
0 1 d 00 13 0c 20 29 00
0 0 2 14 13 13 20 20 01
1 20 0 00 00 00 00 00 00
1 01 0 00 00 00 00 00 00
3 14 0 00 00 00 00 00 00
f

// File: flist.f
src/sched_pkg.sv
src/rs_wr_if.sv
src/free_list.sv
src/rename_table.sv
src/rename_stage.sv
src/reservation_station.sv
src/order_queue.sv
src/scheduler.sv
bench/tb_clock.sv
bench/tb_scheduler.sv

// File: Bender.yml
package:
  name: scheduler

sources:
  - files:
      - src/sched_pkg.sv
      - src/rs_wr_if.sv
      - src/free_list.sv
      - src/rename_table.sv
      - src/rename_stage.sv
      - src/reservation_station.sv
      - src/order_queue.sv
      - src/scheduler.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/tb_scheduler.sv
